/* flist.f */
+incdir+verification
verilog/spmm_pkg.sv
verilog/spmm_apb_pkg.sv
verilog/spmm_regs.sv
verilog/row_sequencer.sv
verilog/node_info_fifo.sv
verilog/sp_pe.sv
verilog/wh_writer.sv
verilog/spmm_top.sv
verification/tb_spmm_top.sv

/* verification/spmm_stimulus.txt */
// Weights W[r][c], one line per row r = 0..15, columns c = 0..3, 8-bit two's complement
// Then section entry counts, entry lines and expected Wh records, all hex
01 FF 02 07
02 FE 04 06
03 FD 06 05
04 FC 08 04
05 FB 0A 03
06 FA 0C 02
07 F9 0E 01
08 F8 10 00
09 F7 12 FF
0A F6 14 FE
0B F5 16 FD
0C F4 18 FC
0D F3 1A FB
0E F2 1C FA
0F F1 1E F9
10 F0 20 F8
// Entry counts: single-entry rows, multi-entry rows, entry offered while disabled
04 0B 01
// Entries: col_idx val first last num_node src_flag
03 05 1 1 02 1
00 F9 1 1 05 0
0F 7F 1 1 0A 1
09 80 1 1 03 0
01 03 1 0 04 1
04 FE 0 0 00 0
0C 0A 0 1 00 0
02 FB 1 0 07 0
07 09 0 1 00 0
0E 64 1 0 01 1
0F 64 0 0 00 0
0D 9C 0 0 00 0
00 01 0 1 00 0
08 FF 1 0 0F 0
06 FF 0 1 00 0
05 2A 1 1 06 1
// Expected Wh in row order: res0 res1 res2 res3 (20-bit two's complement) num_node src_flag
00014 FFFEC 00028 00014 02 1
FFFF9 00007 FFFF2 FFFCF 05 0
007F0 FF810 00FE0 FFC08 0A 1
FFB00 00500 FF600 00100 03 0
0007E FFF82 000FC FFFDA 04 1
00039 FFFC7 00072 FFFE7 07 0
006A5 FF95B 00D4A FFC83 01 1
FFFF0 00010 FFFE0 00000 0F 0
000FC FFF04 001F8 00054 06 1

/* verification/tb_spmm_tasks.svh */
`ifndef TB_SPMM_TASKS_SVH
`define TB_SPMM_TASKS_SVH

// ============================================================================
// APB transfers, setup then access, callers sit 0.5 ns after a rising edge
// ============================================================================
task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                         output logic slv_err);
  apb.psel    = 1'b1;
  apb.penable = 1'b0;
  apb.pwrite  = 1'b1;
  apb.paddr   = addr;
  apb.pwdata  = data;
  @(posedge clk);
  #0.5;
  apb.penable = 1'b1;
  @(negedge clk);
  slv_err = pslverr;
  check_value("pready_o", pready, 1);
  @(posedge clk);
  #0.5;
  apb = '0;
endtask

task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                        output logic slv_err);
  apb.psel    = 1'b1;
  apb.penable = 1'b0;
  apb.pwrite  = 1'b0;
  apb.paddr   = addr;
  @(posedge clk);
  #0.5;
  apb.penable = 1'b1;
  @(negedge clk);
  data    = prdata;
  slv_err = pslverr;
  check_value("pready_o", pready, 1);
  @(posedge clk);
  #0.5;
  apb = '0;
endtask

// ============================================================================
// Entry stream
// ============================================================================
task automatic load_entry(input int idx);
  int base;
  base = ent_base + LINE_WORDS * idx;
  entry.col_idx       = stim[base][spmm_pkg::COL_IDX_WIDTH-1:0];
  entry.val           = stim[base+1][spmm_pkg::DATA_WIDTH-1:0];
  entry.first         = stim[base+2][0];
  entry.last          = stim[base+3][0];
  entry.info.num_node = stim[base+4][spmm_pkg::NUM_NODE_WIDTH-1:0];
  entry.info.src_flag = stim[base+5][0];
endtask

// Holds valid until the entry is taken, a last entry books its record
task automatic send_entry(input int idx);
  logic rdy;
  int   edge_no;
  load_entry(idx);
  entry_valid = 1'b1;
  rdy = 1'b0;
  while (!rdy) begin
    @(negedge clk);
    rdy     = entry_ready;
    edge_no = cycle + 1;
    @(posedge clk);
  end
  if (entry.last) begin
    exp_rec_q.push_back(rec_of_entry[idx]);
    accept_q.push_back(edge_no);
  end
  #0.5;
  entry_valid = 1'b0;
endtask

task automatic send_rows(input int first_idx, input int count, input logic with_gaps);
  int gap;
  for (int i = 0; i < count; i++) begin
    send_entry(first_idx + i);
    gap = 0;
    if (with_gaps) begin
      pick_gap(gap);
    end
    repeat (gap) begin
      @(posedge clk);
      #0.5;
    end
  end
endtask

task automatic wait_drained();
  while (exp_rec_q.size() != 0) begin
    @(posedge clk);
    #0.5;
  end
endtask

// ============================================================================
// Checking
// ============================================================================
task automatic check_value(input string name, input logic [31:0] observed,
                           input logic [31:0] expected);
  if (observed !== expected) begin
    $display("** Error at %t: %s = 0x%0h, expected 0x%0h", $time, name, observed, expected);
    errors++;
  end
endtask

task automatic check_record();
  int rec;
  int acc_edge;
  int base;
  if (exp_rec_q.size() == 0) begin
    $display("Unexpected Wh record at %t while no row was pending", $time);
    failures++;
  end else begin
    rec      = exp_rec_q.pop_front();
    acc_edge = accept_q.pop_front();
    base     = rec_base + LINE_WORDS * rec;
    for (int c = 0; c < NFO; c++) begin
      check_value($sformatf("wh_o.res[%0d]", c), wh.res[c], stim[base+c]);
    end
    check_value("wh_o.info.num_node", wh.info.num_node, stim[base+4]);
    check_value("wh_o.info.src_flag", wh.info.src_flag, stim[base+5]);
    check_value("wh_o.addr", wh.addr, next_addr);
    // Two cycles after the last entry was taken
    check_value("wh_valid_o cycle", cycle, acc_edge + 2);
    next_addr = next_addr + 1'b1;
    records_seen++;
  end
endtask

// ============================================================================
// Random idle gaps
// ============================================================================
function automatic logic [15:0] galois_step(input logic [15:0] s);
  logic [15:0] n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ 16'hB400;
  end
  return n;
endfunction

// Two LFSR bits give a gap of 0 to 3 cycles
task automatic pick_gap(output int gap);
  gap = 0;
  for (int b = 0; b < 2; b++) begin
    gap  = (gap << 1) | int'(lfsr[0]);
    lfsr = galois_step(lfsr);
  end
endtask

`endif

/* verification/tb_spmm_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_spmm_top;

  localparam int NFO = spmm_pkg::NUM_FEATURE_OUT;
  localparam int NUM_WGT = spmm_pkg::NUM_FEATURE_IN * spmm_pkg::NUM_FEATURE_OUT;
  // Entry and record lines both hold six words
  localparam int LINE_WORDS = 6;

  logic clk = 1'b0;
  logic rst_n;

  spmm_apb_pkg::apb_req_t                  apb;
  logic [spmm_apb_pkg::APB_DATA_WIDTH-1:0] prdata;
  logic                                    pready;
  logic                                    pslverr;
  spmm_pkg::h_entry_t                      entry;
  logic                                    entry_valid;
  logic                                    entry_ready;
  spmm_pkg::wh_row_t                       wh;
  logic                                    wh_valid;

  // Stimulus image and its sections
  logic [31:0] stim [0:255];
  int          rec_of_entry [0:63];
  int          n_a;
  int          n_b;
  int          n_c;
  int          ent_base;
  int          rec_base;
  int          n_rec;
  int          rows_b;
  logic        file_ok;

  // Scoreboard
  int                               exp_rec_q[$];
  int                               accept_q[$];
  logic [spmm_pkg::WH_ADDR_WIDTH-1:0] next_addr = '0;
  int                               records_seen = 0;
  int                               errors = 0;
  int                               failures = 0;
  int                               cycle = 0;
  int                               timeout_cycles = 100000;
  logic [15:0]                      lfsr = 16'd39186;
  logic [31:0]                      rdata;
  logic                             err;

  always #2 clk = ~clk;

  spmm_top #(
    .NODE_FIFO_DEPTH (4)
  ) i_spmm_top (
    .clk           (clk),
    .rst_n         (rst_n),
    .apb_i         (apb),
    .prdata_o      (prdata),
    .pready_o      (pready),
    .pslverr_o     (pslverr),
    .entry_i       (entry),
    .entry_valid_i (entry_valid),
    .entry_ready_o (entry_ready),
    .wh_o          (wh),
    .wh_valid_o    (wh_valid)
  );

  // ==========================================================================
  // Cycle count, timeout and record monitor
  // ==========================================================================
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= timeout_cycles) begin
      $display("Timeout: run stopped after %0d cycles, expected records still pending",
               cycle);
      $display("Testbench failed");
      $finish;
    end
  end

  // Records are sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n && wh_valid) begin
      check_record();
    end
  end

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial begin
    $timeformat(-9, 1, " ns", 10);
    rst_n       = 1'b0;
    apb         = '0;
    entry       = '0;
    entry_valid = 1'b0;
    $readmemh("verification/spmm_stimulus.txt", stim);
    file_ok = !$isunknown({stim[NUM_WGT], stim[NUM_WGT+1], stim[NUM_WGT+2]});
    if (file_ok) begin
      n_a      = stim[NUM_WGT];
      n_b      = stim[NUM_WGT+1];
      n_c      = stim[NUM_WGT+2];
      ent_base = NUM_WGT + 3;
      rec_base = ent_base + LINE_WORDS * (n_a + n_b + n_c);
      n_rec    = 0;
      rows_b   = 0;
      for (int i = 0; i < n_a + n_b + n_c; i++) begin
        rec_of_entry[i] = n_rec;
        if (stim[ent_base + LINE_WORDS * i + 3][0]) begin
          n_rec++;
          if (i >= n_a && i < n_a + n_b) begin
            rows_b++;
          end
        end
      end
      file_ok = (n_rec > 0) && !$isunknown(stim[rec_base + LINE_WORDS * n_rec - 1]);
      timeout_cycles = 8 * (NUM_WGT + n_a + 2 * n_b + n_c) + 200;
    end

    repeat (4) @(posedge clk);
    #0.5;
    check_value("entry_ready_o", entry_ready, 0);
    check_value("wh_valid_o", wh_valid, 0);
    check_value("pslverr_o", pslverr, 0);
    rst_n = 1'b1;

    if (file_ok) begin
      // Register access and error responses
      apb_write(spmm_apb_pkg::REG_CTRL, 32'h1, err);
      check_value("pslverr_o", err, 0);
      apb_read(spmm_apb_pkg::REG_CTRL, rdata, err);
      check_value("prdata_o", rdata, 1);
      check_value("pslverr_o", err, 0);
      apb_read(12'h008, rdata, err);
      check_value("pslverr_o", err, 1);
      apb_write(spmm_apb_pkg::REG_STATUS, 32'h5, err);
      check_value("pslverr_o", err, 1);

      // W loaded row by row
      for (int i = 0; i < NUM_WGT; i++) begin
        apb_write(12'(spmm_apb_pkg::REG_WGT_BASE + 4 * i), stim[i], err);
        check_value("pslverr_o", err, 0);
      end

      send_rows(0, n_a, 1'b0);
      wait_drained();
      send_rows(n_a, n_b, 1'b0);
      wait_drained();
      // Same rows again with random idle gaps
      send_rows(n_a, n_b, 1'b1);
      wait_drained();

      // Disabled engine holds off the offered entry
      apb_write(spmm_apb_pkg::REG_CTRL, 32'h0, err);
      load_entry(n_a + n_b);
      entry_valid = 1'b1;
      repeat (8) begin
        @(negedge clk);
        check_value("entry_ready_o", entry_ready, 0);
        @(posedge clk);
        #0.5;
      end
      entry_valid = 1'b0;
      apb_write(spmm_apb_pkg::REG_CTRL, 32'h1, err);
      send_entry(n_a + n_b);
      wait_drained();

      apb_read(spmm_apb_pkg::REG_STATUS, rdata, err);
      check_value("prdata_o", rdata, records_seen);
      check_value("pslverr_o", err, 0);
      check_value("wh record count", records_seen, n_rec + rows_b);
    end else begin
      $display("Stimulus file verification/spmm_stimulus.txt is missing or incomplete");
      failures++;
    end

    $display("Checks done: %0d value errors, %0d other failures", errors, failures);
    if (errors == 0 && failures == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  `include "tb_spmm_tasks.svh"

endmodule

`default_nettype wire

/* verilog/node_info_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module node_info_fifo #(
  parameter int NODE_FIFO_DEPTH = 4
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       push_i,
  input  wire spmm_pkg::node_info_t push_data_i,
  input  wire                       pop_i,
  output spmm_pkg::node_info_t      pop_data_o,
  output logic                      full_o,
  output logic                      empty_o
);

  localparam int PTR_W = $clog2(NODE_FIFO_DEPTH);

  spmm_pkg::node_info_t mem [NODE_FIFO_DEPTH];
  logic [PTR_W:0]       wr_ptr_q;
  logic [PTR_W:0]       rd_ptr_q;

  // Extra pointer MSB separates full from empty
  assign empty_o    = (wr_ptr_q == rd_ptr_q);
  assign full_o     = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                      (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);
  assign pop_data_o = mem[rd_ptr_q[PTR_W-1:0]];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q[PTR_W-1:0]] <= push_data_i;
    end
  end

  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n) push_i |-> !full_o);
  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o);

endmodule

`default_nettype wire

/* verilog/row_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module row_sequencer (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     enable_i,
  input  wire spmm_pkg::h_entry_t entry_i,
  input  wire                     entry_valid_i,
  output logic                    entry_ready_o,
  input  wire                     fifo_full_i,
  output logic                    push_o,
  output spmm_pkg::node_info_t    push_info_o,
  output spmm_pkg::pe_op_t        pe_op_o
);

  spmm_pkg::seq_state_e                   state_q;
  spmm_pkg::seq_state_e                   state_d;
  logic                                   accept;
  logic                                   op_valid_q;
  logic [spmm_pkg::COL_IDX_WIDTH-1:0]     op_col_q;
  logic signed [spmm_pkg::DATA_WIDTH-1:0] op_val_q;
  logic                                   op_first_q;
  logic                                   op_last_q;

  // Stall when disabled or no descriptor slot is left
  assign entry_ready_o = enable_i && !fifo_full_i;
  assign accept        = entry_valid_i && entry_ready_o;

  // Descriptor travels ahead of its results
  assign push_o      = accept && entry_i.first;
  assign push_info_o = entry_i.info;

  always_comb begin
    state_d = state_q;
    if (accept) begin
      state_d = entry_i.last ? spmm_pkg::ROW_START : spmm_pkg::ROW_BODY;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= spmm_pkg::ROW_START;
      op_valid_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      op_valid_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_col_q   <= entry_i.col_idx;
      op_val_q   <= entry_i.val;
      op_first_q <= entry_i.first;
      op_last_q  <= entry_i.last;
    end
  end

  assign pe_op_o.valid   = op_valid_q;
  assign pe_op_o.col_idx = op_col_q;
  assign pe_op_o.val     = op_val_q;
  assign pe_op_o.first   = op_first_q;
  assign pe_op_o.last    = op_last_q;

  // First flag opens a row only after the previous one closed
  a_framing : assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> (entry_i.first == (state_q == spmm_pkg::ROW_START)));

endmodule

`default_nettype wire

/* verilog/sp_pe.sv */
`timescale 1ns/1ps
`default_nettype none

module sp_pe #(
  parameter int COL_INDEX = 0
) (
  input  wire                                   clk,
  input  wire                                   rst_n,
  input  wire spmm_apb_pkg::wgt_wr_t            wgt_wr_i,
  input  wire spmm_pkg::pe_op_t                 pe_op_i,
  output logic [spmm_pkg::WH_DATA_WIDTH-1:0]    res_o,
  output logic                                  res_valid_o
);

  localparam int PROD_WIDTH = 2 * spmm_pkg::DATA_WIDTH;
  localparam int EXT_WIDTH  = spmm_pkg::WH_DATA_WIDTH - PROD_WIDTH;

  logic signed [spmm_pkg::DATA_WIDTH-1:0]    w_mem [spmm_pkg::NUM_FEATURE_IN];
  logic signed [PROD_WIDTH-1:0]              prod;
  logic signed [spmm_pkg::WH_DATA_WIDTH-1:0] acc_q;
  logic signed [spmm_pkg::WH_DATA_WIDTH-1:0] acc_d;

  // =========================================================================
  // Weight column store
  // =========================================================================
  always_ff @(posedge clk) begin
    if (wgt_wr_i.valid && (int'(wgt_wr_i.col) == COL_INDEX)) begin
      w_mem[wgt_wr_i.row] <= wgt_wr_i.wgt;
    end
  end

  // =========================================================================
  // Multiply-accumulate
  // =========================================================================
  assign prod = pe_op_i.val * w_mem[pe_op_i.col_idx];

  // Restart on the first entry of a row
  always_comb begin
    acc_d = (pe_op_i.first ? '0 : acc_q) + {{EXT_WIDTH{prod[PROD_WIDTH-1]}}, prod};
  end

  always_ff @(posedge clk) begin
    if (pe_op_i.valid) begin
      acc_q <= acc_d;
    end
    if (pe_op_i.valid && pe_op_i.last) begin
      res_o <= acc_d;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= pe_op_i.valid && pe_op_i.last;
    end
  end

endmodule

`default_nettype wire

/* verilog/spmm_apb_pkg.sv */
`default_nettype none

package spmm_apb_pkg;

  localparam int APB_ADDR_WIDTH = 12;
  localparam int APB_DATA_WIDTH = 32;
  localparam int WGT_COL_WIDTH  = $clog2(spmm_pkg::NUM_FEATURE_OUT);

  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
  } apb_req_t;

  // Weight (r, c) at REG_WGT_BASE + 4 * (r * NUM_FEATURE_OUT + c)
  typedef enum logic [APB_ADDR_WIDTH-1:0] {
    REG_CTRL     = 12'h000,
    REG_STATUS   = 12'h004,
    REG_WGT_BASE = 12'h100
  } reg_addr_e;

  typedef struct packed {
    logic                                   valid;
    logic [spmm_pkg::COL_IDX_WIDTH-1:0]     row;
    logic [WGT_COL_WIDTH-1:0]               col;
    logic signed [spmm_pkg::DATA_WIDTH-1:0] wgt;
  } wgt_wr_t;

endpackage

`default_nettype wire

/* verilog/spmm_pkg.sv */
`default_nettype none

package spmm_pkg;

  // =========================================================================
  // Matrix sizes and data widths
  // =========================================================================
  localparam int NUM_FEATURE_IN  = 16;
  localparam int NUM_FEATURE_OUT = 4;
  localparam int DATA_WIDTH      = 8;
  // Sum of 16 products of 8x8 bits stays inside 20 bits
  localparam int WH_DATA_WIDTH   = 20;
  localparam int COL_IDX_WIDTH   = 4;
  localparam int NUM_NODE_WIDTH  = 8;
  localparam int WH_ADDR_WIDTH   = 10;

  // =========================================================================
  // Datapath structs
  // =========================================================================
  typedef struct packed {
    logic [NUM_NODE_WIDTH-1:0] num_node;
    logic                      src_flag;
  } node_info_t;

  // One nonzero of H, info only meaningful on the first entry of a row
  typedef struct packed {
    logic [COL_IDX_WIDTH-1:0]     col_idx;
    logic signed [DATA_WIDTH-1:0] val;
    logic                         first;
    logic                         last;
    node_info_t                   info;
  } h_entry_t;

  // Broadcast to all processing elements
  typedef struct packed {
    logic                         valid;
    logic [COL_IDX_WIDTH-1:0]     col_idx;
    logic signed [DATA_WIDTH-1:0] val;
    logic                         first;
    logic                         last;
  } pe_op_t;

  // Column 0 sits in res[0]
  typedef struct packed {
    logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] res;
    node_info_t                                    info;
    logic [WH_ADDR_WIDTH-1:0]                      addr;
  } wh_row_t;

  typedef enum logic {
    ROW_START,
    ROW_BODY
  } seq_state_e;

endpackage

`default_nettype wire

/* verilog/spmm_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module spmm_regs (
  input  wire                                     clk,
  input  wire                                     rst_n,
  input  wire spmm_apb_pkg::apb_req_t             apb_i,
  output logic [spmm_apb_pkg::APB_DATA_WIDTH-1:0] prdata_o,
  output logic                                    pready_o,
  output logic                                    pslverr_o,
  input  wire                                     wh_valid_i,
  output logic                                    enable_o,
  output spmm_apb_pkg::wgt_wr_t                   wgt_wr_o
);

  localparam int WGT_WORDS = spmm_pkg::NUM_FEATURE_IN * spmm_pkg::NUM_FEATURE_OUT;
  localparam int WGT_IDX_W = $clog2(WGT_WORDS);
  localparam int COL_W     = spmm_apb_pkg::WGT_COL_WIDTH;

  logic                                    access;
  logic                                    hit_ctrl;
  logic                                    hit_status;
  logic                                    hit_wgt;
  logic [spmm_apb_pkg::APB_ADDR_WIDTH-1:0] wgt_offset;
  logic [WGT_IDX_W-1:0]                    wgt_idx;
  logic [spmm_apb_pkg::APB_DATA_WIDTH-1:0] row_count_q;

  // =========================================================================
  // Address decode
  // =========================================================================
  assign access     = apb_i.psel && apb_i.penable;
  assign hit_ctrl   = (apb_i.paddr == spmm_apb_pkg::REG_CTRL);
  assign hit_status = (apb_i.paddr == spmm_apb_pkg::REG_STATUS);

  // Weight window is word aligned, one word per weight
  assign wgt_offset = apb_i.paddr - spmm_apb_pkg::REG_WGT_BASE;
  assign hit_wgt    = (apb_i.paddr >= spmm_apb_pkg::REG_WGT_BASE) &&
                      (wgt_offset[1:0] == 2'b00) &&
                      (wgt_offset[spmm_apb_pkg::APB_ADDR_WIDTH-1:2] < WGT_WORDS);
  assign wgt_idx    = wgt_offset[WGT_IDX_W+1:2];

  assign pready_o  = 1'b1;
  assign pslverr_o = access &&
                     (!(hit_ctrl || hit_status || hit_wgt) || (apb_i.pwrite && hit_status));

  // Read mux, weights read back as zero
  always_comb begin
    prdata_o = '0;
    if (access && !apb_i.pwrite) begin
      if (hit_ctrl) begin
        prdata_o[0] = enable_o;
      end else if (hit_status) begin
        prdata_o = row_count_q;
      end
    end
  end

  // Index splits into row (upper bits) and column (lower bits)
  assign wgt_wr_o.valid = access && apb_i.pwrite && hit_wgt;
  assign wgt_wr_o.row   = wgt_idx[WGT_IDX_W-1:COL_W];
  assign wgt_wr_o.col   = wgt_idx[COL_W-1:0];
  assign wgt_wr_o.wgt   = apb_i.pwdata[spmm_pkg::DATA_WIDTH-1:0];

  // =========================================================================
  // Control and status
  // =========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      enable_o    <= 1'b0;
      row_count_q <= '0;
    end else begin
      if (access && apb_i.pwrite && hit_ctrl) begin
        enable_o <= apb_i.pwdata[0];
      end
      if (wh_valid_i) begin
        row_count_q <= row_count_q + 1'b1;
      end
    end
  end

  // Setup phase always leads into its access phase with psel held
  a_psel_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (apb_i.psel && !apb_i.penable) |=> (apb_i.psel && apb_i.penable));

endmodule

`default_nettype wire

/* verilog/spmm_top.sv */
`timescale 1ns/1ps
`default_nettype none

module spmm_top #(
  parameter int NODE_FIFO_DEPTH = 4
) (
  input  wire                                     clk,
  input  wire                                     rst_n,
  // APB slave
  input  wire spmm_apb_pkg::apb_req_t             apb_i,
  output logic [spmm_apb_pkg::APB_DATA_WIDTH-1:0] prdata_o,
  output logic                                    pready_o,
  output logic                                    pslverr_o,
  // Sparse entry stream
  input  wire spmm_pkg::h_entry_t                 entry_i,
  input  wire                                     entry_valid_i,
  output logic                                    entry_ready_o,
  // Wh records
  output spmm_pkg::wh_row_t                       wh_o,
  output logic                                    wh_valid_o
);

  logic                                                         enable;
  spmm_apb_pkg::wgt_wr_t                                        wgt_wr;
  spmm_pkg::pe_op_t                                             pe_op;
  logic                                                         push;
  spmm_pkg::node_info_t                                         push_info;
  logic                                                         fifo_full;
  logic                                                         pop;
  spmm_pkg::node_info_t                                         pop_data;
  logic [spmm_pkg::NUM_FEATURE_OUT-1:0][spmm_pkg::WH_DATA_WIDTH-1:0] res;
  logic [spmm_pkg::NUM_FEATURE_OUT-1:0]                         res_valid;

  spmm_regs i_spmm_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .apb_i      (apb_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .wh_valid_i (wh_valid_o),
    .enable_o   (enable),
    .wgt_wr_o   (wgt_wr)
  );

  row_sequencer i_row_sequencer (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable_i      (enable),
    .entry_i       (entry_i),
    .entry_valid_i (entry_valid_i),
    .entry_ready_o (entry_ready_o),
    .fifo_full_i   (fifo_full),
    .push_o        (push),
    .push_info_o   (push_info),
    .pe_op_o       (pe_op)
  );

  node_info_fifo #(
    .NODE_FIFO_DEPTH (NODE_FIFO_DEPTH)
  ) i_node_info_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (push),
    .push_data_i (push_info),
    .pop_i       (pop),
    .pop_data_o  (pop_data),
    .full_o      (fifo_full),
    .empty_o     ()
  );

  // One processing element per W column, all finish in the same cycle
  for (genvar i = 0; i < spmm_pkg::NUM_FEATURE_OUT; i++) begin : g_pe
    sp_pe #(
      .COL_INDEX (i)
    ) i_sp_pe (
      .clk         (clk),
      .rst_n       (rst_n),
      .wgt_wr_i    (wgt_wr),
      .pe_op_i     (pe_op),
      .res_o       (res[i]),
      .res_valid_o (res_valid[i])
    );
  end

  wh_writer i_wh_writer (
    .clk         (clk),
    .rst_n       (rst_n),
    .res_i       (res),
    .res_valid_i (res_valid[0]),
    .pop_o       (pop),
    .pop_data_i  (pop_data),
    .wh_o        (wh_o),
    .wh_valid_o  (wh_valid_o)
  );

endmodule

`default_nettype wire

/* verilog/wh_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module wh_writer (
  input  wire                                                         clk,
  input  wire                                                         rst_n,
  input  wire [spmm_pkg::NUM_FEATURE_OUT-1:0][spmm_pkg::WH_DATA_WIDTH-1:0] res_i,
  input  wire                                                         res_valid_i,
  output logic                                                        pop_o,
  input  wire spmm_pkg::node_info_t                                   pop_data_i,
  output spmm_pkg::wh_row_t                                           wh_o,
  output logic                                                        wh_valid_o
);

  logic [spmm_pkg::WH_ADDR_WIDTH-1:0] addr_q;

  // Descriptor of the oldest row leaves together with its results
  assign pop_o = res_valid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q     <= '0;
      wh_valid_o <= 1'b0;
    end else begin
      wh_valid_o <= res_valid_i;
      if (res_valid_i) begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  // Record payload
  always_ff @(posedge clk) begin
    if (res_valid_i) begin
      wh_o.res  <= res_i;
      wh_o.info <= pop_data_i;
      wh_o.addr <= addr_q;
    end
  end

  // A pushed descriptor must be waiting when a row's results land
  a_info_ready : assert property (@(posedge clk) disable iff (!rst_n)
    res_valid_i |-> !$isunknown(pop_data_i));

endmodule

`default_nettype wire
